//--- Bender.yml
package:
  name: mandelbrot_display

sources:
  - files:
      - hdl/mandel_pkg.sv
      - hdl/escape_iterator.sv
      - hdl/pixel_scheduler.sv
      - hdl/frame_buffer.sv
      - hdl/vga_scanout.sv
      - hdl/mandelbrot_display.sv

  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_mandelbrot_display.sv

//--- compile.f
+incdir+tb
hdl/mandel_pkg.sv
hdl/escape_iterator.sv
hdl/pixel_scheduler.sv
hdl/frame_buffer.sv
hdl/vga_scanout.sv
hdl/mandelbrot_display.sv
tb/tb_mandelbrot_display.sv

//--- hdl/escape_iterator.sv
`timescale 1ns/1ns

module escape_iterator import mandel_pkg::*; (
	input logic clk,
	input logic reset,
	input logic load,
	input fix_t c_re,
	input fix_t c_im,
	output logic result_valid,
	output iter_count_t iter_count
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_STEP,
		ST_REPORT
	} state_t;

	state_t state;

	// Point under test and current z
	fix_t c_re_q;
	fix_t c_im_q;
	fix_t zr;
	fix_t zi;

	// Per-step arithmetic
	fix_t zr_sq;
	fix_t zi_sq;
	fix_t zr_zi;
	fix_t mag_sq;
	fix_t zr_next;
	fix_t zi_next;
	logic escaped;
	logic at_limit;
	logic stop;

	////////////////////
	// One iteration step
	////////////////////

	always_comb begin
		// Squares of current z
		zr_sq = fix_mul(zr, zr);
		zi_sq = fix_mul(zi, zi);
		zr_zi = fix_mul(zr, zi);
		mag_sq = zr_sq + zi_sq;
		// z^2 + c, doubling as a shift
		zr_next = zr_sq - zi_sq + c_re_q;
		zi_next = (zr_zi <<< 1) + c_im_q;
		// Bailout on magnitude or on either next component
		escaped = (mag_sq > ESCAPE_MAG_SQ)
			|| (zr_next > ESCAPE_COORD) || (zr_next < -ESCAPE_COORD)
			|| (zi_next > ESCAPE_COORD) || (zi_next < -ESCAPE_COORD);
		// Count before the step
		at_limit = iter_count == iter_count_t'(ITER_MAX);
		stop = escaped || at_limit;
	end

	////////////////////
	// Control
	////////////////////

	// A load restarts from any state, so a new render can cut a run short
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_IDLE;
		end else if (load) begin
			state <= ST_STEP;
		end else begin
			case (state)
				ST_STEP: begin
					if (stop) begin
						state <= ST_REPORT;
					end
				end
				// Single result cycle
				ST_REPORT: state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Datapath
	always_ff @(posedge clk) begin
		if (load) begin
			c_re_q <= c_re;
			c_im_q <= c_im;
			zr <= '0;
			zi <= '0;
			iter_count <= '0;
		end else if (state == ST_STEP) begin
			iter_count <= iter_count + 1'b1;
			// z frozen once the run stops
			if (!stop) begin
				zr <= zr_next;
				zi <= zi_next;
			end
		end
	end

	assign result_valid = (state == ST_REPORT);

endmodule

//--- hdl/frame_buffer.sv
`timescale 1ns/1ns

module frame_buffer import mandel_pkg::*; (
	input logic clk,
	input fb_write_t fb_write,
	input pixel_addr_t read_addr,
	output color_t read_color
);

	// One colour word per pixel
	color_t mem [PIXELS];

	////////////////////
	// Write port
	////////////////////

	always_ff @(posedge clk) begin
		if (fb_write.valid) begin
			mem[fb_write.addr] <= fb_write.color;
		end
	end

	////////////////////
	// Read port
	////////////////////

	// Registered read, same-address write gives old data
	always_ff @(posedge clk) begin
		read_color <= mem[read_addr];
	end

endmodule

//--- hdl/mandel_pkg.sv
package mandel_pkg;

	////////////////////
	// Fixed point and iteration
	////////////////////

	// 4.23 signed format
	localparam int FRAC_BITS = 23;
	localparam int FIX_WIDTH = 27;

	// Escape-time limit and count width
	localparam int ITER_MAX = 1000;
	localparam int COUNT_WIDTH = 11;

	////////////////////
	// Frame and VGA timing
	////////////////////

	// Horizontal, in clocks
	localparam int H_ACTIVE = 640;
	localparam int H_FRONT = 16;
	localparam int H_PULSE = 96;
	localparam int H_BACK = 48;

	// Vertical, in lines
	localparam int V_ACTIVE = 480;
	localparam int V_FRONT = 10;
	localparam int V_PULSE = 2;
	localparam int V_BACK = 33;

	// Frame-buffer depth and address width
	localparam int PIXELS = H_ACTIVE * V_ACTIVE;
	localparam int ADDR_WIDTH = 19;
	localparam int COORD_WIDTH = 10;

	typedef logic signed [FIX_WIDTH-1:0] fix_t;
	typedef logic [COUNT_WIDTH-1:0] iter_count_t;
	typedef logic [ADDR_WIDTH-1:0] pixel_addr_t;
	typedef logic [COORD_WIDTH-1:0] screen_coord_t;
	// Packed RRR_GGG_BB
	typedef logic [7:0] color_t;

	// Bailout bounds, 4.0 and 2.0
	localparam fix_t ESCAPE_MAG_SQ = fix_t'(4 << FRAC_BITS);
	localparam fix_t ESCAPE_COORD = fix_t'(2 << FRAC_BITS);

	// Colour bands, deepest first
	localparam color_t COLOR_INSIDE = 8'b000_000_00;
	localparam color_t COLOR_BAND_HIGH = 8'b011_001_00;
	localparam color_t COLOR_BAND_MID = 8'b101_010_01;
	localparam color_t COLOR_BAND_62 = 8'b011_001_01;
	localparam color_t COLOR_BAND_31 = 8'b001_001_01;
	localparam color_t COLOR_BAND_15 = 8'b011_010_10;
	localparam color_t COLOR_OUTSIDE = 8'b010_100_10;

	// Render request
	typedef struct packed {
		fix_t x_start;
		fix_t y_start;
		fix_t step;
	} view_t;

	// One frame-buffer write
	typedef struct packed {
		logic valid;
		pixel_addr_t addr;
		color_t color;
	} fb_write_t;

	// VGA colour channels
	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgb_t;

	// 4.23 product; sign bit of full product over bits 48..23
	function automatic fix_t fix_mul(input fix_t a, input fix_t b);
		logic signed [2*FIX_WIDTH-1:0] product;
		product = a * b;
		return {product[2*FIX_WIDTH-1], product[FRAC_BITS+FIX_WIDTH-2:FRAC_BITS]};
	endfunction

endpackage

//--- hdl/mandelbrot_display.sv
`timescale 1ns/1ns

module mandelbrot_display import mandel_pkg::*; (
	input logic clk,
	input logic reset,
	input logic render_start,
	input view_t view,
	output logic render_done,
	output logic hsync,
	output logic vsync,
	output logic video_active,
	output rgb_t rgb
);

	// Render side into the buffer
	fb_write_t fb_write;

	// Display side out of the buffer
	pixel_addr_t read_addr;
	color_t read_color;

	////////////////////
	// Renderer
	////////////////////

	pixel_scheduler u_scheduler (
		.clk(clk),
		.reset(reset),
		.render_start(render_start),
		.view(view),
		.fb_write(fb_write),
		.render_done(render_done)
	);

	// Pixel memory between renderer and display
	frame_buffer u_frame_buffer (
		.clk(clk),
		.fb_write(fb_write),
		.read_addr(read_addr),
		.read_color(read_color)
	);

	////////////////////
	// Display
	////////////////////

	vga_scanout u_scanout (
		.clk(clk),
		.reset(reset),
		.read_addr(read_addr),
		.read_color(read_color),
		.hsync(hsync),
		.vsync(vsync),
		.video_active(video_active),
		.rgb(rgb)
	);

endmodule

//--- hdl/pixel_scheduler.sv
`timescale 1ns/1ns

module pixel_scheduler import mandel_pkg::*; (
	input logic clk,
	input logic reset,
	input logic render_start,
	input view_t view,
	output fb_write_t fb_write,
	output logic render_done
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ISSUE,
		ST_WAIT,
		ST_FINISHED
	} state_t;

	state_t state;

	// Latched view and running coordinate
	view_t view_q;
	fix_t c_re;
	fix_t c_im;

	// Pixel walk
	screen_coord_t pix_x;
	screen_coord_t pix_y;
	pixel_addr_t addr;
	logic line_end;
	logic last_pixel;
	logic write_now;

	// Iterator handshake
	logic load;
	logic result_valid;
	iter_count_t iter_count;

	// Thresholds halve from ITER_MAX downwards
	function automatic color_t color_map(input iter_count_t count);
		if (count >= iter_count_t'(ITER_MAX)) return COLOR_INSIDE;
		else if (count >= iter_count_t'(ITER_MAX >> 1)) return COLOR_BAND_HIGH;
		else if (count >= iter_count_t'(ITER_MAX >> 2)) return COLOR_BAND_HIGH;
		else if (count >= iter_count_t'(ITER_MAX >> 3)) return COLOR_BAND_MID;
		else if (count >= iter_count_t'(ITER_MAX >> 4)) return COLOR_BAND_62;
		else if (count >= iter_count_t'(ITER_MAX >> 5)) return COLOR_BAND_31;
		else if (count >= iter_count_t'(ITER_MAX >> 6)) return COLOR_BAND_15;
		else return COLOR_OUTSIDE;
	endfunction

	escape_iterator u_iterator (
		.clk(clk),
		.reset(reset),
		.load(load),
		.c_re(c_re),
		.c_im(c_im),
		.result_valid(result_valid),
		.iter_count(iter_count)
	);

	assign line_end = pix_x == screen_coord_t'(H_ACTIVE - 1);
	assign last_pixel = line_end && (pix_y == screen_coord_t'(V_ACTIVE - 1));
	// Result lands straight in the buffer
	assign write_now = (state == ST_WAIT) && result_valid;

	////////////////////
	// FSM and walk
	////////////////////

	// render_start wins in every state
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_IDLE;
			pix_x <= '0;
			pix_y <= '0;
			addr <= '0;
		end else if (render_start) begin
			state <= ST_ISSUE;
			pix_x <= '0;
			pix_y <= '0;
			addr <= '0;
		end else begin
			case (state)
				ST_ISSUE: state <= ST_WAIT;
				ST_WAIT: begin
					if (result_valid) begin
						state <= last_pixel ? ST_FINISHED : ST_ISSUE;
						addr <= addr + 1'b1;
						// Row-major step
						if (line_end) begin
							pix_x <= '0;
							pix_y <= pix_y + 1'b1;
						end else begin
							pix_x <= pix_x + 1'b1;
						end
					end
				end
				default: state <= state;
			endcase
		end
	end

	// c_re back to x_start per line, c_im down one step per line
	always_ff @(posedge clk) begin
		if (render_start) begin
			view_q <= view;
			c_re <= view.x_start;
			c_im <= view.y_start;
		end else if (write_now) begin
			if (line_end) begin
				c_re <= view_q.x_start;
				c_im <= c_im - view_q.step;
			end else begin
				c_re <= c_re + view_q.step;
			end
		end
	end

	assign load = (state == ST_ISSUE);
	assign render_done = (state == ST_FINISHED);

	always_comb begin
		fb_write.valid = write_now;
		fb_write.addr = addr;
		fb_write.color = color_map(iter_count);
	end

endmodule

//--- hdl/vga_scanout.sv
`timescale 1ns/1ns

module vga_scanout import mandel_pkg::*; (
	input logic clk,
	input logic reset,
	output pixel_addr_t read_addr,
	input color_t read_color,
	output logic hsync,
	output logic vsync,
	output logic video_active,
	output rgb_t rgb
);

	typedef enum logic [1:0] {
		H_ST_ACTIVE,
		H_ST_FRONT,
		H_ST_PULSE,
		H_ST_BACK
	} h_state_t;

	typedef enum logic [1:0] {
		V_ST_ACTIVE,
		V_ST_FRONT,
		V_ST_PULSE,
		V_ST_BACK
	} v_state_t;

	// Sync and blanking travel together down the pipe
	typedef struct packed {
		logic hsync;
		logic vsync;
		logic active;
	} scan_flags_t;

	localparam scan_flags_t FLAGS_IDLE = '{hsync: 1'b1, vsync: 1'b1, active: 1'b0};

	h_state_t h_state;
	h_state_t h_state_next;
	screen_coord_t h_count;
	logic h_last;

	v_state_t v_state;
	v_state_t v_state_next;
	screen_coord_t v_count;
	logic v_last;
	logic line_end;

	scan_flags_t flags_now;
	scan_flags_t flags_d1;
	scan_flags_t flags_d2;

	////////////////////
	// Horizontal
	////////////////////

	// Last clock of each segment
	always_comb begin
		case (h_state)
			H_ST_ACTIVE: begin
				h_last = h_count == screen_coord_t'(H_ACTIVE - 1);
				h_state_next = H_ST_FRONT;
			end
			H_ST_FRONT: begin
				h_last = h_count == screen_coord_t'(H_FRONT - 1);
				h_state_next = H_ST_PULSE;
			end
			H_ST_PULSE: begin
				h_last = h_count == screen_coord_t'(H_PULSE - 1);
				h_state_next = H_ST_BACK;
			end
			default: begin
				h_last = h_count == screen_coord_t'(H_BACK - 1);
				h_state_next = H_ST_ACTIVE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			h_state <= H_ST_ACTIVE;
			h_count <= '0;
		end else if (h_last) begin
			h_state <= h_state_next;
			h_count <= '0;
		end else begin
			h_count <= h_count + 1'b1;
		end
	end

	// End of back porch closes the line
	assign line_end = h_last && (h_state == H_ST_BACK);

	////////////////////
	// Vertical
	////////////////////

	always_comb begin
		case (v_state)
			V_ST_ACTIVE: begin
				v_last = v_count == screen_coord_t'(V_ACTIVE - 1);
				v_state_next = V_ST_FRONT;
			end
			V_ST_FRONT: begin
				v_last = v_count == screen_coord_t'(V_FRONT - 1);
				v_state_next = V_ST_PULSE;
			end
			V_ST_PULSE: begin
				v_last = v_count == screen_coord_t'(V_PULSE - 1);
				v_state_next = V_ST_BACK;
			end
			default: begin
				v_last = v_count == screen_coord_t'(V_BACK - 1);
				v_state_next = V_ST_ACTIVE;
			end
		endcase
	end

	// Advances once per line
	always_ff @(posedge clk) begin
		if (reset) begin
			v_state <= V_ST_ACTIVE;
			v_count <= '0;
		end else if (line_end) begin
			if (v_last) begin
				v_state <= v_state_next;
				v_count <= '0;
			end else begin
				v_count <= v_count + 1'b1;
			end
		end
	end

	////////////////////
	// Read and output
	////////////////////

	// Linear pixel address, always inside the buffer
	assign read_addr = pixel_addr_t'(v_count) * pixel_addr_t'(H_ACTIVE)
		+ pixel_addr_t'(h_count);

	always_comb begin
		flags_now.hsync = (h_state != H_ST_PULSE);
		flags_now.vsync = (v_state != V_ST_PULSE);
		flags_now.active = (h_state == H_ST_ACTIVE) && (v_state == V_ST_ACTIVE);
	end

	// Stage 1 waits on the RAM, stage 2 is the output register
	always_ff @(posedge clk) begin
		if (reset) begin
			flags_d1 <= FLAGS_IDLE;
			flags_d2 <= FLAGS_IDLE;
			rgb <= '0;
		end else begin
			flags_d1 <= flags_now;
			flags_d2 <= flags_d1;
			// Fields to top bits of each channel
			if (flags_d1.active) begin
				rgb.red <= {read_color[7:5], 5'b0};
				rgb.green <= {read_color[4:2], 5'b0};
				rgb.blue <= {read_color[1:0], 6'b0};
			end else begin
				rgb <= '0;
			end
		end
	end

	assign hsync = flags_d2.hsync;
	assign vsync = flags_d2.vsync;
	assign video_active = flags_d2.active;

endmodule

//--- tb/mandel_model.svh
`ifndef MANDEL_MODEL_SVH
`define MANDEL_MODEL_SVH

////////////////////
// Fixed-point model
////////////////////

// 4.23 signed, as rendered
localparam int MODEL_FRAC = 23;
localparam int MODEL_ITER_LIMIT = 1000;

typedef logic signed [26:0] model_fix_t;

// Bailout bounds 4.0 and 2.0
localparam model_fix_t MODEL_MAG_LIMIT = model_fix_t'(4 * (1 << MODEL_FRAC));
localparam model_fix_t MODEL_COORD_LIMIT = model_fix_t'(2 * (1 << MODEL_FRAC));

// Product sign over bits 48..23 of the full product
function automatic model_fix_t fix_product(input model_fix_t a, input model_fix_t b);
	longint full;
	longint scaled;
	full = longint'(a) * longint'(b);
	scaled = full >>> MODEL_FRAC;
	return {full[63], scaled[25:0]};
endfunction

// c_re after x column steps
function automatic model_fix_t column_re(input model_fix_t x_start, input model_fix_t step,
	input int x);
	model_fix_t re;
	re = x_start;
	for (int i = 0; i < x; i++) begin
		re = re + step;
	end
	return re;
endfunction

// c_im after y line steps, going down
function automatic model_fix_t line_im(input model_fix_t y_start, input model_fix_t step,
	input int y);
	model_fix_t im;
	im = y_start;
	for (int i = 0; i < y; i++) begin
		im = im - step;
	end
	return im;
endfunction

////////////////////
// Escape rule
////////////////////

function automatic int escape_count(input model_fix_t c_re, input model_fix_t c_im);
	model_fix_t zr;
	model_fix_t zi;
	model_fix_t zr_sq;
	model_fix_t zi_sq;
	model_fix_t mag_sq;
	model_fix_t zr_next;
	model_fix_t zi_next;
	int count;
	logic done;
	zr = '0;
	zi = '0;
	count = 0;
	done = 1'b0;
	while (!done) begin
		zr_sq = fix_product(zr, zr);
		zi_sq = fix_product(zi, zi);
		mag_sq = zr_sq + zi_sq;
		zr_next = zr_sq - zi_sq + c_re;
		// Doubling wraps inside 27 bits
		zi_next = fix_product(zr, zi) * 2 + c_im;
		if (mag_sq > MODEL_MAG_LIMIT || count == MODEL_ITER_LIMIT
			|| zr_next > MODEL_COORD_LIMIT || zr_next < -MODEL_COORD_LIMIT
			|| zi_next > MODEL_COORD_LIMIT || zi_next < -MODEL_COORD_LIMIT) begin
			done = 1'b1;
		end
		count++;
		zr = zr_next;
		zi = zi_next;
	end
	return count;
endfunction

// Colour bands, top threshold first
function automatic logic [7:0] band_color(input int count);
	if (count >= 1000) return 8'b000_000_00;
	else if (count >= 500) return 8'b011_001_00;
	else if (count >= 250) return 8'b011_001_00;
	else if (count >= 125) return 8'b101_010_01;
	else if (count >= 62) return 8'b011_001_01;
	else if (count >= 31) return 8'b001_001_01;
	else if (count >= 15) return 8'b011_010_10;
	else return 8'b010_100_10;
endfunction

// RRR_GGG_BB into the top bits of each channel
function automatic logic [23:0] expand_color(input logic [7:0] c);
	return {c[7:5], 5'b0, c[4:2], 5'b0, c[1:0], 6'b0};
endfunction

`endif

//--- tb/tb_mandelbrot_display.sv
`timescale 1ns/1ns

module tb_mandelbrot_display;

	`include "mandel_model.svh"

	////////////////////
	// Timing constants
	////////////////////

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 3;
	localparam int H_ACTIVE = 640;
	localparam int H_FRONT = 16;
	localparam int H_PULSE = 96;
	localparam int V_ACTIVE = 480;
	localparam int V_PULSE = 2;
	localparam int LINE_CLOCKS = 800;
	localparam int FRAME_CLOCKS = LINE_CLOCKS * 525;
	localparam int PIXELS = H_ACTIVE * V_ACTIVE;
	// Two worst-case renders plus four frames
	localparam longint WATCHDOG_CYCLES =
		2 * longint'(PIXELS) * (MODEL_ITER_LIMIT + 3) + 4 * longint'(FRAME_CLOCKS);

	// View points, raw 4.23
	localparam model_fix_t X_UNIFORM = 27'sd20971520;
	localparam model_fix_t X_MIXED = 27'sd4194304;
	localparam model_fix_t Y_START = 27'sd8388608;
	localparam model_fix_t STEP = 27'sd39000;

	logic clk;
	logic reset;
	logic render_start;
	logic [80:0] view;
	logic render_done;
	logic hsync;
	logic vsync;
	logic video_active;
	logic [23:0] rgb;

	integer seed;
	int mismatch_count = 0;
	int failure_count = 0;
	// One captured frame, row-major
	logic [23:0] frame_rgb [PIXELS];

	mandelbrot_display UUT (
		.clk(clk),
		.reset(reset),
		.render_start(render_start),
		.view(view),
		.render_done(render_done),
		.hsync(hsync),
		.vsync(vsync),
		.video_active(video_active),
		.rgb(rgb)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	////////////////////
	// Reporting
	////////////////////

	task automatic report_mismatch(input string name, input logic [63:0] got,
		input logic [63:0] expected);
		$display("error at %0t ns: %s is %0d (0x%0h), expected %0d (0x%0h)",
			$time, name, got, got, expected, expected);
		mismatch_count++;
	endtask

	task automatic report_failure(input string what);
		$display("failure at %0t ns: %s", $time, what);
		failure_count++;
	endtask

	task automatic print_summary();
		$display("value errors: %0d, other errors: %0d", mismatch_count, failure_count);
	endtask

	// Runaway guard
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		report_failure("watchdog expired before the tests finished");
		print_summary();
		$display("*** TEST FAILED ***");
		$finish;
	end

	////////////////////
	// Stimulus helpers
	////////////////////

	task automatic apply_reset();
		reset = 1'b1;
		repeat (RESET_CYCLES) @(negedge clk);
		reset = 1'b0;
	endtask

	// One-cycle pulse with the view beside it
	task automatic start_render(input model_fix_t x_start, input model_fix_t y_start,
		input model_fix_t step);
		view = {x_start, y_start, step};
		render_start = 1'b1;
		@(negedge clk);
		render_start = 1'b0;
	endtask

	task automatic wait_render_done();
		while (render_done !== 1'b1) begin
			@(negedge clk);
		end
	endtask

	// Returns at the first sample after the vsync pulse
	task automatic wait_vsync_end();
		while (vsync !== 1'b0) begin
			@(negedge clk);
		end
		while (vsync !== 1'b1) begin
			@(negedge clk);
		end
	endtask

	// Active cycles counted per line, lines counted from vsync end
	task automatic capture_frame();
		int x;
		int y;
		logic va_prev;
		wait_vsync_end();
		x = 0;
		y = 0;
		va_prev = 1'b0;
		while (y < V_ACTIVE) begin
			@(negedge clk);
			if (video_active) begin
				if (x < H_ACTIVE) begin
					frame_rgb[y * H_ACTIVE + x] = rgb;
				end
				x++;
			end else if (va_prev) begin
				x = 0;
				y++;
			end
			va_prev = video_active;
		end
	endtask

	task automatic compare_pixel(input int x, input int y, input model_fix_t x_start,
		input model_fix_t y_start, input model_fix_t step);
		int count;
		logic [23:0] expected;
		count = escape_count(column_re(x_start, step, x), line_im(y_start, step, y));
		expected = expand_color(band_color(count));
		if (frame_rgb[y * H_ACTIVE + x] !== expected) begin
			report_mismatch($sformatf("rgb(%0d,%0d)", x, y),
				frame_rgb[y * H_ACTIVE + x], expected);
		end
	endtask

	// Corners plus random points against the model
	task automatic sample_model_pixels(input model_fix_t x_start, input model_fix_t y_start,
		input model_fix_t step, input int count);
		int x;
		int y;
		compare_pixel(0, 0, x_start, y_start, step);
		compare_pixel(H_ACTIVE - 1, 0, x_start, y_start, step);
		compare_pixel(0, V_ACTIVE - 1, x_start, y_start, step);
		compare_pixel(H_ACTIVE - 1, V_ACTIVE - 1, x_start, y_start, step);
		for (int n = 0; n < count; n++) begin
			x = {$random(seed)} % H_ACTIVE;
			y = {$random(seed)} % V_ACTIVE;
			compare_pixel(x, y, x_start, y_start, step);
		end
	endtask

	////////////////////
	// Directed tests
	////////////////////

	task automatic check_reset_state();
		if (render_done !== 1'b0) report_mismatch("render_done", render_done, 0);
		if (video_active !== 1'b0) report_mismatch("video_active", video_active, 0);
		if (hsync !== 1'b1) report_mismatch("hsync", hsync, 1);
		if (vsync !== 1'b1) report_mismatch("vsync", vsync, 1);
		if (rgb !== 24'h0) report_mismatch("rgb", rgb, 0);
	endtask

	// Two full frames from one vsync end to the next but one
	task automatic measure_sync_timing();
		int cycle;
		int frames;
		int frame_start;
		int line_start;
		int last_hs_fall;
		int hs_low;
		int vs_low;
		int active_run;
		int active_cycles;
		int active_lines;
		logic hs_prev;
		logic vs_prev;
		logic va_prev;
		wait_vsync_end();
		cycle = 0;
		frames = 0;
		frame_start = 0;
		line_start = -1;
		last_hs_fall = -1;
		hs_low = 0;
		vs_low = 0;
		active_run = 0;
		active_cycles = 0;
		active_lines = 0;
		hs_prev = hsync;
		vs_prev = vsync;
		va_prev = video_active;
		while (frames < 2) begin
			@(negedge clk);
			cycle++;
			if (!video_active && rgb !== 24'h0) report_mismatch("blanked rgb", rgb, 0);
			// Active runs and lines
			if (video_active) begin
				if (!va_prev) line_start = cycle;
				active_run++;
				active_cycles++;
			end else if (va_prev) begin
				if (active_run != H_ACTIVE) report_mismatch("active run", active_run, H_ACTIVE);
				active_run = 0;
				active_lines++;
			end
			// hsync edge position and width
			if (!hsync) hs_low++;
			if (!hsync && hs_prev) begin
				if (line_start >= 0 && cycle - line_start != H_ACTIVE + H_FRONT) begin
					report_mismatch("hsync fall offset", cycle - line_start, H_ACTIVE + H_FRONT);
				end
				line_start = -1;
				if (last_hs_fall >= 0 && cycle - last_hs_fall != LINE_CLOCKS) begin
					report_mismatch("hsync period", cycle - last_hs_fall, LINE_CLOCKS);
				end
				last_hs_fall = cycle;
			end
			if (hsync && !hs_prev) begin
				if (hs_low != H_PULSE) report_mismatch("hsync low clocks", hs_low, H_PULSE);
				hs_low = 0;
			end
			// Frame totals close at vsync end
			if (!vsync) vs_low++;
			if (vsync && !vs_prev) begin
				if (vs_low != V_PULSE * LINE_CLOCKS) begin
					report_mismatch("vsync low clocks", vs_low, V_PULSE * LINE_CLOCKS);
				end
				if (cycle - frame_start != FRAME_CLOCKS) begin
					report_mismatch("frame length", cycle - frame_start, FRAME_CLOCKS);
				end
				if (active_cycles != PIXELS) report_mismatch("active cycles", active_cycles, PIXELS);
				if (active_lines != V_ACTIVE) report_mismatch("active lines", active_lines, V_ACTIVE);
				vs_low = 0;
				active_cycles = 0;
				active_lines = 0;
				frame_start = cycle;
				frames++;
			end
			hs_prev = hsync;
			vs_prev = vsync;
			va_prev = video_active;
		end
	endtask

	// Whole view right of 2.0, every pixel escapes on step one
	task automatic render_uniform_view();
		int x;
		int y;
		logic [23:0] expected;
		expected = expand_color(band_color(1));
		start_render(X_UNIFORM, Y_START, STEP);
		wait_render_done();
		capture_frame();
		for (int n = 0; n < 64; n++) begin
			x = {$random(seed)} % H_ACTIVE;
			y = {$random(seed)} % V_ACTIVE;
			if (frame_rgb[y * H_ACTIVE + x] !== expected) begin
				report_mismatch($sformatf("rgb(%0d,%0d)", x, y),
					frame_rgb[y * H_ACTIVE + x], expected);
			end
		end
	endtask

	task automatic render_mixed_view();
		start_render(X_MIXED, Y_START, STEP);
		wait_render_done();
		capture_frame();
		sample_model_pixels(X_MIXED, Y_START, STEP, 200);
	endtask

	// New request on top of a finished render
	task automatic restart_render();
		start_render(X_UNIFORM, Y_START, STEP);
		if (render_done !== 1'b0) report_mismatch("render_done", render_done, 0);
		wait_render_done();
		capture_frame();
		sample_model_pixels(X_UNIFORM, Y_START, STEP, 64);
	endtask

	////////////////////
	// Sequence
	////////////////////

	initial begin
		seed = 6185;
		reset = 1'b1;
		render_start = 1'b0;
		view = '0;
		apply_reset();
		check_reset_state();
		measure_sync_timing();
		render_uniform_view();
		render_mixed_view();
		restart_render();
		print_summary();
		if (mismatch_count == 0 && failure_count == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule
